// File: sim/pinmux_tests.txt
# op idx data be gpio_in event expected name, numbers in hex
# WR and RD go over the bus, RST GOUT GDIR GIN INTR check DUT outputs
RD   00 00000000 0 00000000 00000000 82681301 chip_id
RD   02 00000000 0 00000000 00000000 00000000 glbl_rst_val
RST  00 00000000 0 00000000 00000000 00000000 rst_outs_low
RD   07 00000000 0 00000000 00000000 00000000 unmapped_rd
WR   02 12345321 3 00000000 00000000 00000000 glbl_wr_low
RD   02 00000000 0 00000000 00000000 00005321 glbl_rd_low
RST  00 00000000 0 00000000 00000000 00000321 rst_outs_follow
WR   02 ffffff02 c 00000000 00000000 00000000 glbl_wr_high
RD   02 00000000 0 00000000 00000000 ffff5321 glbl_rd_high
WR   05 deadbeef f 00000000 00000000 00000000 gout_wr
RD   05 00000000 0 00000000 00000000 deadbeef gout_rd
GOUT 00 00000000 0 00000000 00000000 deadbeef gout_pins
WR   06 0f0f00ff f 00000000 00000000 00000000 gdir_wr
RD   06 00000000 0 00000000 00000000 0f0f00ff gdir_rd
GDIR 00 00000000 0 00000000 00000000 0f0f00ff gdir_pins
GIN  00 00000000 0 5a5ac3c3 00000000 5a5ac3c3 gin_pins
RD   04 00000000 0 5a5ac3c3 00000000 5a5ac3c3 gin_rd
WR   0a 00000081 f 00000000 00000000 00000000 int_w1s
RD   09 00000000 0 00000000 00000000 00000081 int_rd_clr_idx
RD   0a 00000000 0 00000000 00000000 00000081 int_rd_set_idx
WR   09 00000081 f 00000000 00000000 00000000 int_w1c
RD   09 00000000 0 00000000 00010000 00010000 int_event_post
WR   0a 00000004 f 00000000 00000000 00000000 int_w1s_other
WR   09 00000004 f 00000000 00000000 00000000 int_w1c_other
RD   09 00000000 0 00000000 00000000 00010000 int_event_kept
INTR 00 00000000 0 00000000 00000000 00000000 intr_masked
WR   0b 00010000 f 00000000 00000000 00000000 mask_on
INTR 00 00000000 0 00000000 00000000 00000001 intr_mask_on
WR   09 00010000 f 00000000 00000000 00000000 int_clr_event
INTR 00 00000000 0 00000000 00000000 00000000 intr_after_clr
WR   0a 00010000 f 00000000 00000000 00000000 int_set_again
INTR 00 00000000 0 00000000 00000000 00000001 intr_after_set
WR   0b 00000000 f 00000000 00000000 00000000 mask_off
INTR 00 00000000 0 00000000 00000000 00000000 intr_mask_off

// File: compile.f
+incdir+design
design/pinmux_pkg.sv
design/reg_wr_if.sv
design/reg_bus_ctrl.sv
design/glbl_cfg_regs.sv
design/gpio_in_sync.sv
design/gpio_int_status.sv
design/pinmux_reg_top.sv
sim/pinmux_tb.sv

// File: Bender.yml
package:
  name: pinmux_reg

sources:
  - include_dirs:
      - design
    files:
      - design/pinmux_pkg.sv
      - design/reg_wr_if.sv
      - design/reg_bus_ctrl.sv
      - design/glbl_cfg_regs.sv
      - design/gpio_in_sync.sv
      - design/gpio_int_status.sv
      - design/pinmux_reg_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/pinmux_tb.sv

// File: sim/pinmux_tb.sv
//------------------------------
// Pinmux register block testbench,
// file-driven bus and pin checks
//------------------------------
`timescale 1ns/1ps
`include "pinmux_defines.svh"

module pinmux_tb;

   localparam int CLK_HALF    = 20;   // 40 ns period
   localparam int RST_CYCLES  = 16;
   localparam int ACK_TIMEOUT = 20;   // Cycles allowed for an ack

   logic                  mclk;
   logic                  h_reset_n;
   logic                  reg_cs;
   logic                  reg_wr;
   logic [7:0]            reg_addr;
   pinmux_pkg::reg_data_t reg_wdata;
   pinmux_pkg::reg_be_t   reg_be;
   pinmux_pkg::reg_data_t reg_rdata;
   logic                  reg_ack;
   pinmux_pkg::core_rst_t cpu_core_rst_n;
   logic                  cpu_intf_rst_n;
   logic                  qspim_rst_n;
   logic                  sspim_rst_n;
   logic                  uart_rst_n;
   logic                  i2cm_rst_n;
   logic                  usb_rst_n;
   pinmux_pkg::gpio_vec_t gpio_in_data;
   pinmux_pkg::gpio_vec_t gpio_int_event;
   pinmux_pkg::gpio_vec_t cfg_gpio_out_data;
   pinmux_pkg::gpio_vec_t cfg_gpio_dir_sel;
   pinmux_pkg::gpio_vec_t cfg_gpio_data_in;
   pinmux_pkg::gpio_vec_t gpio_prev_indata;
   logic                  gpio_intr;

   int num_tests;    // Lines run
   int num_errors;   // Lines failed

   pinmux_reg_top dut_i (
      .mclk              (mclk),
      .h_reset_n         (h_reset_n),
      .reg_cs            (reg_cs),
      .reg_wr            (reg_wr),
      .reg_addr          (reg_addr),
      .reg_wdata         (reg_wdata),
      .reg_be            (reg_be),
      .reg_rdata         (reg_rdata),
      .reg_ack           (reg_ack),
      .cpu_core_rst_n    (cpu_core_rst_n),
      .cpu_intf_rst_n    (cpu_intf_rst_n),
      .qspim_rst_n       (qspim_rst_n),
      .sspim_rst_n       (sspim_rst_n),
      .uart_rst_n        (uart_rst_n),
      .i2cm_rst_n        (i2cm_rst_n),
      .usb_rst_n         (usb_rst_n),
      .gpio_in_data      (gpio_in_data),
      .gpio_int_event    (gpio_int_event),
      .cfg_gpio_out_data (cfg_gpio_out_data),
      .cfg_gpio_dir_sel  (cfg_gpio_dir_sel),
      .cfg_gpio_data_in  (cfg_gpio_data_in),
      .gpio_prev_indata  (gpio_prev_indata),
      .gpio_intr         (gpio_intr)
   );

   initial
   begin
      mclk = 1'b0;
      forever
      begin
         #CLK_HALF mclk = ~mclk;
      end
   end

   //------------------------------
   // Bus access and checks
   //------------------------------
   // Called right after a rising edge, returns after cs drops
   task automatic bus_access(input logic wr, input pinmux_pkg::reg_idx_t idx,
                             input pinmux_pkg::reg_data_t data,
                             input pinmux_pkg::reg_be_t be,
                             output pinmux_pkg::reg_data_t rdata, output logic acked);
      int waited;
      waited = 0;
      acked  = 1'b0;
      reg_cs    <= 1'b1;
      reg_wr    <= wr;
      reg_addr  <= {1'b0, idx, 2'b00};   // Word index to byte address
      reg_wdata <= data;
      reg_be    <= be;
      while (!acked && waited < ACK_TIMEOUT)
      begin
         @(negedge mclk);                // Ack and rdata stable here
         if (reg_ack)
            acked = 1'b1;
         else
            waited++;
      end
      rdata = reg_rdata;
      @(posedge mclk);
      reg_cs <= 1'b0;                    // Cycle after the ack
      reg_wr <= 1'b0;
   endtask

   task automatic check_value(input logic [8*24-1:0] name,
                              input pinmux_pkg::reg_data_t exp,
                              input pinmux_pkg::reg_data_t got);
      assert (got === exp)
         $display("Pass %0s value %08h", name, got);
      else
      begin
         $display("Error %0s expected %08h actual %08h", name, exp, got);
         num_errors++;
      end
   endtask

   // One line of the test file
   task automatic run_test(input logic [8*8-1:0] op, input pinmux_pkg::reg_idx_t idx,
                           input pinmux_pkg::reg_data_t data, input pinmux_pkg::reg_be_t be,
                           input pinmux_pkg::gpio_vec_t gin, input pinmux_pkg::gpio_vec_t evt,
                           input pinmux_pkg::reg_data_t exp, input logic [8*24-1:0] name);
      pinmux_pkg::reg_data_t got;
      logic                  acked;
      @(posedge mclk);
      gpio_in_data   <= gin;
      gpio_int_event <= evt;    // One-cycle event pulse
      @(posedge mclk);
      gpio_int_event <= '0;
      repeat (3) @(posedge mclk);   // Pins held 4 cycles before the op
      num_tests++;
      if (op == "WR" || op == "RD")
      begin
         bus_access(op == "WR", idx, data, be, got, acked);
         assert (acked)
         else
         begin
            $display("Bus timeout in %0s, no ack within %0d cycles", name, ACK_TIMEOUT);
            num_errors++;
         end
         if (acked && op == "RD")
            check_value(name, exp, got);
         else if (acked)
            $display("Pass %0s write acked", name);
      end
      else
      begin
         @(negedge mclk);   // Outputs settled
         case (op)
            "RST"  : check_value(name, exp, {22'b0, cpu_core_rst_n, 2'b00, usb_rst_n,
                                  i2cm_rst_n, uart_rst_n, sspim_rst_n, qspim_rst_n,
                                  cpu_intf_rst_n});   // Same layout as global control
            "GOUT" : check_value(name, exp, cfg_gpio_out_data);
            "GDIR" : check_value(name, exp, cfg_gpio_dir_sel);
            // Both sync stages hold the pins, report the first one that differs
            "GIN"  : check_value(name, exp, (gpio_prev_indata !== exp) ? gpio_prev_indata
                                                                       : cfg_gpio_data_in);
            "INTR" : check_value(name, exp, {31'b0, gpio_intr});
            default:
            begin
               $display("Unknown operation %0s in test %0s", op, name);
               num_errors++;
            end
         endcase
      end
   endtask

   task automatic report_and_finish;
      $display("Tests run %0d, failed %0d", num_tests, num_errors);
      if (num_errors == 0 && num_tests > 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   endtask

   //------------------------------
   // Main sequence
   //------------------------------
   initial
   begin
      int                    fd;
      int                    cnt;
      string                 line;
      logic [8*8-1:0]        op;
      pinmux_pkg::reg_idx_t  idx;
      pinmux_pkg::reg_data_t data;
      pinmux_pkg::reg_be_t   be;
      pinmux_pkg::gpio_vec_t gin;
      pinmux_pkg::gpio_vec_t evt;
      pinmux_pkg::reg_data_t exp;
      logic [8*24-1:0]       name;
      num_tests      = 0;
      num_errors     = 0;
      h_reset_n      = 1'b0;
      reg_cs         = 1'b0;
      reg_wr         = 1'b0;
      reg_addr       = '0;
      reg_wdata      = '0;
      reg_be         = '0;
      gpio_in_data   = '0;
      gpio_int_event = '0;
      repeat (RST_CYCLES) @(posedge mclk);
      h_reset_n <= 1'b1;
      fd = $fopen("sim/pinmux_tests.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the test file sim/pinmux_tests.txt");
         num_errors++;
      end
      else
      begin
         while (!$feof(fd))
         begin
            cnt = $fgets(line, fd);
            if (cnt > 1 && line.getc(0) != "#")   // Skip comments and blanks
            begin
               cnt = $sscanf(line, "%s %h %h %h %h %h %h %s",
                             op, idx, data, be, gin, evt, exp, name);
               if (cnt != 8)
               begin
                  $display("Malformed line in the test file: %0s", line);
                  num_errors++;
               end
               else
                  run_test(op, idx, data, be, gin, evt, exp, name);
            end
         end
         $fclose(fd);
      end
      report_and_finish();
   end

endmodule

// File: design/pinmux_reg_top.sv
//------------------------------
// Pinmux register block top, bus control
// plus config, GPIO input and interrupt banks
//------------------------------
`timescale 1ns/1ps

module pinmux_reg_top (
   input  logic                  mclk,
   input  logic                  h_reset_n,

   // Register bus
   input  logic                  reg_cs,
   input  logic                  reg_wr,
   input  logic [7:0]            reg_addr,
   input  pinmux_pkg::reg_data_t reg_wdata,
   input  pinmux_pkg::reg_be_t   reg_be,
   output pinmux_pkg::reg_data_t reg_rdata,
   output logic                  reg_ack,

   // Block resets, active low
   output pinmux_pkg::core_rst_t cpu_core_rst_n,
   output logic                  cpu_intf_rst_n,
   output logic                  qspim_rst_n,
   output logic                  sspim_rst_n,
   output logic                  uart_rst_n,
   output logic                  i2cm_rst_n,
   output logic                  usb_rst_n,

   // GPIO
   input  pinmux_pkg::gpio_vec_t gpio_in_data,
   input  pinmux_pkg::gpio_vec_t gpio_int_event,
   output pinmux_pkg::gpio_vec_t cfg_gpio_out_data,
   output pinmux_pkg::gpio_vec_t cfg_gpio_dir_sel,
   output pinmux_pkg::gpio_vec_t cfg_gpio_data_in,
   output pinmux_pkg::gpio_vec_t gpio_prev_indata,
   output logic                  gpio_intr
);

   pinmux_pkg::reg_data_t glbl_ctrl;
   pinmux_pkg::gpio_vec_t int_mask;
   pinmux_pkg::gpio_vec_t int_status;

   reg_wr_if u_wr_bus ();

   reg_bus_ctrl u_bus_ctrl (
      .mclk       (mclk),
      .h_reset_n  (h_reset_n),
      .reg_cs     (reg_cs),
      .reg_wr     (reg_wr),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_be     (reg_be),
      .reg_rdata  (reg_rdata),
      .reg_ack    (reg_ack),
      .wr_bus     (u_wr_bus.ctrl),
      .glbl_ctrl  (glbl_ctrl),
      .gpio_out   (cfg_gpio_out_data),
      .gpio_dir   (cfg_gpio_dir_sel),
      .int_mask   (int_mask),
      .gpio_in    (cfg_gpio_data_in),
      .int_status (int_status)
   );

   glbl_cfg_regs u_cfg_regs (
      .mclk       (mclk),
      .h_reset_n  (h_reset_n),
      .wr_bus     (u_wr_bus.bank),
      .glbl_ctrl  (glbl_ctrl),
      .gpio_out   (cfg_gpio_out_data),
      .gpio_dir   (cfg_gpio_dir_sel),
      .int_mask   (int_mask)
   );

   gpio_in_sync u_in_sync (
      .mclk             (mclk),
      .h_reset_n        (h_reset_n),
      .gpio_in_data     (gpio_in_data),
      .gpio_prev_indata (gpio_prev_indata),
      .gpio_in          (cfg_gpio_data_in)
   );

   gpio_int_status u_int_status (
      .mclk           (mclk),
      .h_reset_n      (h_reset_n),
      .gpio_int_event (gpio_int_event),
      .int_mask       (int_mask),
      .wr_bus         (u_wr_bus.bank),
      .int_status     (int_status),
      .gpio_intr      (gpio_intr)
   );

   //------------------------------
   // Global control to block resets
   //------------------------------
   assign cpu_intf_rst_n = glbl_ctrl[0];
   assign qspim_rst_n    = glbl_ctrl[1];
   assign sspim_rst_n    = glbl_ctrl[2];
   assign uart_rst_n     = glbl_ctrl[3];
   assign i2cm_rst_n     = glbl_ctrl[4];
   assign usb_rst_n      = glbl_ctrl[5];
   assign cpu_core_rst_n = glbl_ctrl[9:8];   // One bit per core

endmodule

// File: design/gpio_int_status.sv
//------------------------------
// GPIO interrupt status, W1C / W1S,
// and masked interrupt output
//------------------------------
`timescale 1ns/1ps
`include "pinmux_defines.svh"

module gpio_int_status (
   input  logic                  mclk,
   input  logic                  h_reset_n,
   input  pinmux_pkg::gpio_vec_t gpio_int_event,  // From GPIO control
   input  pinmux_pkg::gpio_vec_t int_mask,

   reg_wr_if.bank                wr_bus,

   output pinmux_pkg::gpio_vec_t int_status,
   output logic                  gpio_intr        // To the CPU
);

   localparam int NUM_BYTES = `PINMUX_DATA_W / 8;

   logic                  wr_clr;      // Write at the W1C index
   logic                  wr_set;      // Write at the W1S index
   pinmux_pkg::gpio_vec_t status_nxt;

   assign wr_clr = wr_bus.wr_stb & (wr_bus.idx == `PINMUX_IDX_INT_CLR);
   assign wr_set = wr_bus.wr_stb & (wr_bus.idx == `PINMUX_IDX_INT_SET);

   //------------------------------
   // Next status per byte lane
   //------------------------------
   always_comb
   begin
      status_nxt = int_status;
      for (int b = 0; b < NUM_BYTES; b++)
      begin
         if (wr_clr && wr_bus.be[b])
         begin
            status_nxt[b*8 +: 8] = int_status[b*8 +: 8] & ~wr_bus.wdata[b*8 +: 8];
         end
         else if (wr_set && wr_bus.be[b])
         begin
            status_nxt[b*8 +: 8] = int_status[b*8 +: 8] | wr_bus.wdata[b*8 +: 8];
         end
      end
      // New events win over a clear in the same cycle
      status_nxt = status_nxt | gpio_int_event;
   end

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         int_status <= '0;
      end
      else
      begin
         int_status <= status_nxt;   // Updated every cycle
      end
   end

   assign gpio_intr = |(int_status & int_mask);   // Any enabled pending bit

endmodule

// File: design/gpio_in_sync.sv
//------------------------------
// GPIO input synchroniser and
// capture register
//------------------------------
`timescale 1ns/1ps

module gpio_in_sync (
   input  logic                  mclk,
   input  logic                  h_reset_n,
   input  pinmux_pkg::gpio_vec_t gpio_in_data,      // Async pad inputs
   output pinmux_pkg::gpio_vec_t gpio_prev_indata,  // Second sync stage
   output pinmux_pkg::gpio_vec_t gpio_in            // Capture stage
);

   pinmux_pkg::gpio_vec_t sync_s;    // First stage, may be metastable
   pinmux_pkg::gpio_vec_t sync_ss;   // Settled

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         sync_s  <= '0;
         sync_ss <= '0;
         gpio_in <= '0;
      end
      else
      begin
         sync_s  <= gpio_in_data;
         sync_ss <= sync_s;
         gpio_in <= sync_ss;    // Three cycles from the pad
      end
   end

   // Previous sample for edge detect downstream
   assign gpio_prev_indata = sync_ss;

endmodule

// File: design/glbl_cfg_regs.sv
//------------------------------
// Global control, GPIO out/dir and
// interrupt mask registers
//------------------------------
`timescale 1ns/1ps
`include "pinmux_defines.svh"

module glbl_cfg_regs (
   input  logic                  mclk,
   input  logic                  h_reset_n,

   reg_wr_if.bank                wr_bus,

   output pinmux_pkg::reg_data_t glbl_ctrl,   // Block resets
   output pinmux_pkg::gpio_vec_t gpio_out,    // Pad output data
   output pinmux_pkg::gpio_vec_t gpio_dir,    // Pad direction
   output pinmux_pkg::gpio_vec_t int_mask     // Interrupt enables
);

   localparam int NUM_BYTES = `PINMUX_DATA_W / 8;

   // Per-register write hits
   logic wr_glbl;
   logic wr_out;
   logic wr_dir;
   logic wr_mask;

   assign wr_glbl = wr_bus.wr_stb & (wr_bus.idx == `PINMUX_IDX_GLBL_CTRL);
   assign wr_out  = wr_bus.wr_stb & (wr_bus.idx == `PINMUX_IDX_GPIO_OUT);
   assign wr_dir  = wr_bus.wr_stb & (wr_bus.idx == `PINMUX_IDX_GPIO_DIR);
   assign wr_mask = wr_bus.wr_stb & (wr_bus.idx == `PINMUX_IDX_INT_MASK);

   //------------------------------
   // Byte-lane update
   //------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         glbl_ctrl <= `PINMUX_GLBL_CTRL_RST;  // All blocks in reset
         gpio_out  <= '0;
         gpio_dir  <= '0;                     // All pads input
         int_mask  <= '0;                     // Interrupts masked
      end
      else
      begin
         for (int b = 0; b < NUM_BYTES; b++)
         begin
            if (wr_bus.be[b])
            begin
               if (wr_glbl)
               begin
                  glbl_ctrl[b*8 +: 8] <= wr_bus.wdata[b*8 +: 8];
               end
               if (wr_out)
               begin
                  gpio_out[b*8 +: 8] <= wr_bus.wdata[b*8 +: 8];
               end
               if (wr_dir)
               begin
                  gpio_dir[b*8 +: 8] <= wr_bus.wdata[b*8 +: 8];
               end
               if (wr_mask)
               begin
                  int_mask[b*8 +: 8] <= wr_bus.wdata[b*8 +: 8];
               end
            end
         end
      end
   end

endmodule

// File: design/reg_bus_ctrl.sv
//------------------------------
// Register bus control: write strobe,
// registered ack and read-data mux
//------------------------------
`timescale 1ns/1ps
`include "pinmux_defines.svh"

module reg_bus_ctrl (
   input  logic                  mclk,
   input  logic                  h_reset_n,

   // Register bus
   input  logic                  reg_cs,
   input  logic                  reg_wr,
   input  logic [7:0]            reg_addr,
   input  pinmux_pkg::reg_data_t reg_wdata,
   input  pinmux_pkg::reg_be_t   reg_be,
   output pinmux_pkg::reg_data_t reg_rdata,
   output logic                  reg_ack,

   // Write path to the banks
   reg_wr_if.ctrl                wr_bus,

   // Read-back from the banks
   input  pinmux_pkg::reg_data_t glbl_ctrl,
   input  pinmux_pkg::reg_data_t gpio_out,
   input  pinmux_pkg::reg_data_t gpio_dir,
   input  pinmux_pkg::reg_data_t int_mask,
   input  pinmux_pkg::reg_data_t gpio_in,
   input  pinmux_pkg::reg_data_t int_status
);

   pinmux_pkg::reg_idx_t  idx;       // Word index
   pinmux_pkg::reg_data_t reg_out;   // Mux output, unregistered
   logic                  acc_start; // First cycle of an access

   assign idx       = reg_addr[6:2];       // Byte address to word
   assign acc_start = reg_cs & ~reg_ack;   // Low again after each ack

   // Write strobe, lands on the ack edge
   assign wr_bus.wr_stb = acc_start & reg_wr;
   assign wr_bus.idx    = idx;
   assign wr_bus.wdata  = reg_wdata;
   assign wr_bus.be     = reg_be;

   //------------------------------
   // Read-data mux
   //------------------------------
   always_comb
   begin
      case (idx)
         `PINMUX_IDX_CHIP_ID   : reg_out = {`PINMUX_MANU_ID, `PINMUX_TOTAL_CORE,
                                            `PINMUX_CHIP_ID, `PINMUX_CHIP_REV};
         `PINMUX_IDX_GLBL_CTRL : reg_out = glbl_ctrl;
         `PINMUX_IDX_GPIO_IN   : reg_out = gpio_in;
         `PINMUX_IDX_GPIO_OUT  : reg_out = gpio_out;
         `PINMUX_IDX_GPIO_DIR  : reg_out = gpio_dir;
         `PINMUX_IDX_INT_CLR,
         `PINMUX_IDX_INT_SET   : reg_out = int_status;  // Same status view at both
         `PINMUX_IDX_INT_MASK  : reg_out = int_mask;
         default               : reg_out = '0;          // Unmapped
      endcase
   end

   //------------------------------
   // Ack and read data, one cycle
   //------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         reg_ack   <= 1'b0;
         reg_rdata <= '0;
      end
      else
      begin
         reg_ack <= acc_start;   // Single-cycle pulse
         if (acc_start)
         begin
            reg_rdata <= reg_out;   // Captured with the ack
         end
      end
   end

endmodule

// File: design/reg_wr_if.sv
//------------------------------
// Decoded register write path
//------------------------------
`timescale 1ns/1ps

interface reg_wr_if;

   logic                  wr_stb;  // One-cycle write pulse
   pinmux_pkg::reg_idx_t  idx;     // Word index
   pinmux_pkg::reg_data_t wdata;   // Write data
   pinmux_pkg::reg_be_t   be;      // Byte enables

   // Bus controller side
   modport ctrl (output wr_stb, output idx, output wdata, output be);

   // Register bank side, each bank decodes its own indices
   modport bank (input wr_stb, input idx, input wdata, input be);

endinterface

// File: design/pinmux_pkg.sv
//------------------------------
// Pinmux shared vector types
//------------------------------
`include "pinmux_defines.svh"

package pinmux_pkg;

   // One register word on the bus
   typedef logic [`PINMUX_DATA_W-1:0]   reg_data_t;

   // Word index taken from addr[6:2]
   typedef logic [`PINMUX_IDX_W-1:0]    reg_idx_t;

   // One enable per data byte
   typedef logic [`PINMUX_DATA_W/8-1:0] reg_be_t;

   // One bit per GPIO pin
   typedef logic [`PINMUX_NUM_GPIO-1:0] gpio_vec_t;

   // CPU core resets, active low
   typedef logic [1:0]                  core_rst_t;

endpackage

// File: design/pinmux_defines.svh
//------------------------------
// Pinmux register block widths, word map,
// reset values and chip ID fields
//------------------------------
`ifndef PINMUX_DEFINES_SVH
`define PINMUX_DEFINES_SVH

// Widths
`define PINMUX_DATA_W         32     // Register word
`define PINMUX_NUM_GPIO       32     // GPIO pin count
`define PINMUX_IDX_W          5      // Word index, addr[6:2]

// Word indices of the kept registers
`define PINMUX_IDX_CHIP_ID    5'd0   // Read-only ID
`define PINMUX_IDX_GLBL_CTRL  5'd2   // Block resets
`define PINMUX_IDX_GPIO_IN    5'd4   // Captured pin data
`define PINMUX_IDX_GPIO_OUT   5'd5   // Output data
`define PINMUX_IDX_GPIO_DIR   5'd6   // Pad direction
`define PINMUX_IDX_INT_CLR    5'd9   // Status, write one to clear
`define PINMUX_IDX_INT_SET    5'd10  // Status alias, write one to set
`define PINMUX_IDX_INT_MASK   5'd11  // Interrupt enable

// Chip ID fields, high to low
`define PINMUX_MANU_ID        16'h8268
`define PINMUX_TOTAL_CORE     4'h1
`define PINMUX_CHIP_ID        4'h3
`define PINMUX_CHIP_REV       8'h01

// Every block held in reset after power-up
`define PINMUX_GLBL_CTRL_RST  32'h0

`endif
